// ==== tb.f ====
+incdir+testbench
hw/cpu_pkg.sv
hw/byte_memory.sv
hw/register_file.sv
hw/alu.sv
hw/core_control.sv
hw/minmax_system.sv
testbench/tb_minmax_system.sv

// ==== testbench/program_model.svh ====
`ifndef PROGRAM_MODEL_SVH
`define PROGRAM_MODEL_SVH

// byte array image of the whole memory
localparam int model_bytes = 32'h4000;

typedef bit [7:0] model_mem_t [model_bytes];
typedef logic [31:0] prog_t [$];

function automatic logic [31:0] pack_instr(input logic [3:0] op, input logic [2:0] rd,
                                           input logic [2:0] rs1, input logic [2:0] rs2,
                                           input logic [15:0] imm);
    // bits 18 to 16 are unused
    return {op, rd, rs1, rs2, 3'b000, imm};
endfunction

function automatic logic [31:0] enc_halt();
    return pack_instr(op_halt, 3'd0, 3'd0, 3'd0, 16'h0000);
endfunction

function automatic logic [31:0] enc_li(input logic [2:0] rd, input logic [15:0] imm);
    return pack_instr(op_li, rd, 3'd0, 3'd0, imm);
endfunction

function automatic logic [31:0] enc_load(input logic [2:0] rd, input logic [15:0] addr);
    return pack_instr(op_load, rd, 3'd0, 3'd0, addr);
endfunction

// the stored register sits in the rs2 field
function automatic logic [31:0] enc_store(input logic [2:0] rs2, input logic [15:0] addr);
    return pack_instr(op_store, 3'd0, 3'd0, rs2, addr);
endfunction

function automatic logic [31:0] enc_add(input logic [2:0] rd, input logic [2:0] rs1,
                                        input logic [2:0] rs2);
    return pack_instr(op_add, rd, rs1, rs2, 16'h0000);
endfunction

function automatic logic [31:0] enc_sub(input logic [2:0] rd, input logic [2:0] rs1,
                                        input logic [2:0] rs2);
    return pack_instr(op_sub, rd, rs1, rs2, 16'h0000);
endfunction

function automatic logic [31:0] enc_min(input logic [2:0] rd, input logic [2:0] rs1,
                                        input logic [2:0] rs2);
    return pack_instr(op_min, rd, rs1, rs2, 16'h0000);
endfunction

function automatic logic [31:0] enc_max(input logic [2:0] rd, input logic [2:0] rs1,
                                        input logic [2:0] rs2);
    return pack_instr(op_max, rd, rs1, rs2, 16'h0000);
endfunction

function automatic logic [31:0] enc_unnamed(input logic [3:0] code);
    return pack_instr(code, 3'd0, 3'd0, 3'd0, 16'h0000);
endfunction

// little endian word at a word aligned address
function automatic logic [31:0] model_read(input model_mem_t mem, input logic [13:0] addr);
    logic [13:0] base;
    base = {addr[13:2], 2'b00};
    return {mem[base + 14'd3], mem[base + 14'd2], mem[base + 14'd1], mem[base]};
endfunction

// runs a straight-line program, stops at halt or any unnamed opcode
function automatic model_mem_t ref_run(input model_mem_t mem_in, input prog_t prog);
    model_mem_t  mem;
    logic [31:0] regs [8];
    logic [31:0] ins;
    logic [13:0] a;
    int signed   va;
    int signed   vb;
    bit          running;
    mem = mem_in;
    for (int r = 0; r < 8; r++)
    begin
        regs[r] = 32'h0;
    end
    running = 1'b1;
    for (int i = 0; i < prog.size() && running; i++)
    begin
        ins = prog[i];
        a   = {ins[13:2], 2'b00};
        va  = regs[ins[24:22]];
        vb  = regs[ins[21:19]];
        case (ins[31:28])
            op_li:    regs[ins[27:25]] = {{16{ins[15]}}, ins[15:0]};
            op_load:  regs[ins[27:25]] = model_read(mem, a);
            op_store:
            begin
                for (int b = 0; b < 4; b++)
                begin
                    mem[a + 14'(b)] = regs[ins[21:19]][8*b +: 8];
                end
            end
            op_add:   regs[ins[27:25]] = va + vb;
            op_sub:   regs[ins[27:25]] = va - vb;
            op_min:   regs[ins[27:25]] = (vb < va) ? vb : va;
            op_max:   regs[ins[27:25]] = (vb > va) ? vb : va;
            default:  running = 1'b0;
        endcase
    end
    return mem;
endfunction

`endif

// ==== testbench/tb_minmax_system.sv ====
module tb_minmax_system
    import cpu_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    `include "program_model.svh"

    localparam int unsigned seed        = 32'h89400d51;
    localparam int          clk_period  = 100;
    localparam int unsigned mem_size    = 32'h4000;
    localparam int unsigned code_base   = 32'h3000;
    localparam int          rt_count    = 16;
    localparam int          rt_rewrites = 4;
    localparam int          arith_len   = 14;
    localparam int          minmax_runs = 3;
    localparam int          min_len     = 4;
    localparam int          max_len     = 12;

    logic        mem_write;
    logic        rst_n;
    logic        start_valid;
    logic        start_ready;
    logic        busy;
    logic        host_valid;
    logic        host_ready;
    logic        host_we;
    logic [13:0] host_addr;
    logic [31:0] host_wdata;
    logic        host_rvalid;
    logic [31:0] host_rdata;

    model_mem_t  shadow;
    logic [31:0] exp_q [$];
    logic [13:0] addr_q [$];
    string       name_q [$];
    string       current_test;
    int          value_errors;
    int          protocol_errors;
    int          reads_accepted;
    int          reads_answered;
    int          budget_cycles;
    bit          budget_ready;
    int          arr_len [minmax_runs];

    minmax_system #(
        .mem_size  (mem_size),
        .code_base (code_base)
    ) i_minmax_system (
        .mem_write   (mem_write),
        .rst_n       (rst_n),
        .start_valid (start_valid),
        .start_ready (start_ready),
        .busy        (busy),
        .host_valid  (host_valid),
        .host_ready  (host_ready),
        .host_we     (host_we),
        .host_addr   (host_addr),
        .host_wdata  (host_wdata),
        .host_rvalid (host_rvalid),
        .host_rdata  (host_rdata)
    );

    always #(clk_period / 2) mem_write = ~mem_write;

    function automatic int test_cycles(input int n_instr, input int n_host);
        return n_instr * 4 + n_host * 2 + 20;
    endfunction

    function automatic void shadow_store(input logic [13:0] addr, input logic [31:0] data);
        logic [13:0] base;
        base = {addr[13:2], 2'b00};
        for (int b = 0; b < 4; b++)
        begin
            shadow[base + 14'(b)] = data[8*b +: 8];
        end
    endfunction

    task automatic check_signal(input string what, input logic expected, input logic actual);
        assert (actual === expected)
        else
        begin
            value_errors++;
            $display("ERROR %s %s expected %b actual %b", current_test, what, expected, actual);
        end
    endtask

    // called just after a falling edge, returns one falling edge after the transfer
    task automatic host_drive(input bit we, input logic [13:0] addr, input logic [31:0] wdata);
        host_valid = 1'b1;
        host_we    = we;
        host_addr  = addr;
        host_wdata = wdata;
        while (!host_ready)
        begin
            @(negedge mem_write);
        end
        if (we)
        begin
            shadow_store(addr, wdata);
        end
        else
        begin
            exp_q.push_back(model_read(shadow, addr));
            addr_q.push_back(addr);
            name_q.push_back(current_test);
            reads_accepted++;
        end
        @(negedge mem_write);
    endtask

    task automatic host_release();
        host_valid = 1'b0;
        host_we    = 1'b0;
    endtask

    task automatic drain_responses();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < 8)
        begin
            @(negedge mem_write);
            waited++;
        end
        assert (exp_q.size() == 0)
        else
        begin
            protocol_errors++;
            $display("%s: %0d read responses never arrived", current_test, exp_q.size());
            exp_q.delete();
            addr_q.delete();
            name_q.delete();
        end
        // idle cycles so a stray response pulse is still seen
        repeat (2) @(negedge mem_write);
        assert (reads_answered == reads_accepted)
        else
        begin
            protocol_errors++;
            $display("%s: %0d reads accepted but %0d responses seen", current_test,
                     reads_accepted, reads_answered);
            reads_answered = reads_accepted;
        end
    endtask

    task automatic read_words(input logic [13:0] base, input int count);
        for (int i = 0; i < count; i++)
        begin
            host_drive(1'b0, base + 14'(4 * i), 32'h0);
        end
        host_release();
        drain_responses();
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (2) @(negedge mem_write);
        rst_n = 1'b1;
        @(negedge mem_write);
        check_signal("busy", 1'b0, busy);
        check_signal("host_rvalid", 1'b0, host_rvalid);
        check_signal("start_ready", 1'b1, start_ready);
        check_signal("host_ready", 1'b1, host_ready);
    endtask

    // poke drives host and start requests early in the run, all must be ignored
    task automatic run_program(input int n_instr, input bit poke, input logic [13:0] poke_addr);
        int cycles;
        int limit;
        limit       = n_instr * 4 + 20;
        start_valid = 1'b1;
        while (!start_ready)
        begin
            @(negedge mem_write);
        end
        @(negedge mem_write);
        start_valid = 1'b0;
        assert (busy)
        else
        begin
            protocol_errors++;
            $display("%s: busy did not rise after the start was accepted", current_test);
        end
        cycles = 0;
        while (busy && cycles < limit)
        begin
            assert (!start_ready && !host_ready)
            else
            begin
                protocol_errors++;
                $display("%s: a ready signal was high while the core was busy", current_test);
            end
            if (poke)
            begin
                case (cycles)
                    1:
                    begin
                        host_valid = 1'b1;
                        host_we    = 1'b1;
                        host_addr  = poke_addr;
                        host_wdata = ~model_read(shadow, poke_addr);
                    end
                    2:
                    begin
                        host_valid  = 1'b0;
                        start_valid = 1'b1;
                    end
                    3:
                    begin
                        start_valid = 1'b0;
                        host_valid  = 1'b1;
                        host_we     = 1'b0;
                    end
                    4:
                    begin
                        host_release();
                    end
                    default:
                    begin
                    end
                endcase
            end
            @(negedge mem_write);
            cycles++;
        end
        host_release();
        start_valid = 1'b0;
        assert (!busy)
        else
        begin
            protocol_errors++;
            $display("%s: busy still high after %0d cycles", current_test, limit);
        end
    endtask

    task automatic execute_program(input prog_t prog, input bit poke, input logic [13:0] poke_addr);
        for (int i = 0; i < prog.size(); i++)
        begin
            host_drive(1'b1, 14'(code_base + 4 * i), prog[i]);
        end
        host_release();
        run_program(prog.size(), poke, poke_addr);
        shadow = ref_run(shadow, prog);
    endtask

    // compares every read response against the queued expectation
    always @(negedge mem_write)
    begin
        logic [31:0] expected;
        logic [13:0] addr;
        string       name;
        if (rst_n && host_rvalid)
        begin
            reads_answered++;
            assert (exp_q.size() != 0)
            else
            begin
                protocol_errors++;
                $display("%s: host_rvalid pulsed with no read outstanding", current_test);
            end
            if (exp_q.size() != 0)
            begin
                expected = exp_q.pop_front();
                addr     = addr_q.pop_front();
                name     = name_q.pop_front();
                assert (host_rdata === expected)
                else
                begin
                    value_errors++;
                    $display("ERROR %s addr 0x%04h expected 0x%08h actual 0x%08h", name, addr,
                             expected, host_rdata);
                end
            end
        end
    end

    initial
    begin
        wait (budget_ready);
        #(budget_cycles * clk_period);
        $display("timeout: run did not finish within %0d clock cycles", budget_cycles);
        $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
        $display(">>> FAIL");
        $finish;
    end

    initial
    begin
        logic [13:0] rt_addr [rt_count];
        logic [13:0] base;
        logic [13:0] res;
        logic [31:0] val;
        prog_t       prog;
        int          n;
        mem_write       = 1'b0;
        rst_n           = 1'b0;
        start_valid     = 1'b0;
        host_valid      = 1'b0;
        host_we         = 1'b0;
        host_addr       = 14'h0;
        host_wdata      = 32'h0;
        value_errors    = 0;
        protocol_errors = 0;
        reads_accepted  = 0;
        reads_answered  = 0;
        void'($urandom(seed));
        for (int r = 0; r < minmax_runs; r++)
        begin
            arr_len[r] = min_len + int'($urandom % (max_len - min_len + 1));
        end

        // time limit from the length of every test
        budget_cycles = test_cycles(0, 0);
        budget_cycles += test_cycles(0, 2 * rt_count + rt_rewrites);
        budget_cycles += test_cycles(arith_len, arith_len + 5);
        for (int r = 0; r < minmax_runs; r++)
        begin
            n = 3 * arr_len[r] + 2;
            budget_cycles += test_cycles(n, arr_len[r] + n + 2);
        end
        budget_cycles += test_cycles(8, 12);
        budget_cycles += test_cycles(4, 6);
        budget_cycles += test_cycles(0, 3);
        budget_ready = 1'b1;

        current_test = "reset_state";
        apply_reset();

        current_test = "host_round_trip";
        for (int i = 0; i < rt_count; i++)
        begin
            rt_addr[i] = 14'(($urandom % 32'hC00) * 4);
            host_drive(1'b1, rt_addr[i], $urandom);
        end
        for (int i = 0; i < rt_rewrites; i++)
        begin
            host_drive(1'b1, rt_addr[i], $urandom);
        end
        // back to back reads
        for (int i = 0; i < rt_count; i++)
        begin
            host_drive(1'b0, rt_addr[i], 32'h0);
        end
        host_release();
        drain_responses();

        current_test = "arithmetic";
        prog = {};
        prog.push_back(enc_li(3'd1, 16'($urandom)));
        prog.push_back(enc_li(3'd2, 16'($urandom)));
        prog.push_back(enc_li(3'd3, 16'($urandom)));
        prog.push_back(enc_add(3'd4, 3'd1, 3'd2));
        prog.push_back(enc_sub(3'd5, 3'd2, 3'd3));
        prog.push_back(enc_add(3'd6, 3'd3, 3'd3));
        prog.push_back(enc_sub(3'd7, 3'd1, 3'd3));
        prog.push_back(enc_add(3'd0, 3'd4, 3'd5));
        prog.push_back(enc_store(3'd4, 16'h0100));
        prog.push_back(enc_store(3'd5, 16'h0104));
        prog.push_back(enc_store(3'd6, 16'h0108));
        prog.push_back(enc_store(3'd7, 16'h010C));
        prog.push_back(enc_store(3'd0, 16'h0110));
        prog.push_back(enc_halt());
        execute_program(prog, 1'b0, 14'h0);
        read_words(14'h0100, 5);

        current_test = "min_max";
        for (int r = 0; r < minmax_runs; r++)
        begin
            base = 14'h0400 + 14'(64 * r);
            res  = 14'h0800 + 14'(8 * r);
            for (int i = 0; i < arr_len[r]; i++)
            begin
                val = $urandom;
                // one run holds both extreme values
                if (r == 1 && i == 1)
                begin
                    val = 32'h8000_0000;
                end
                if (r == 1 && i == arr_len[r] - 2)
                begin
                    val = 32'h7FFF_FFFF;
                end
                host_drive(1'b1, base + 14'(4 * i), val);
            end
            host_release();
            prog = {};
            prog.push_back(enc_load(3'd2, 16'(base)));
            prog.push_back(enc_load(3'd3, 16'(base)));
            for (int i = 1; i < arr_len[r]; i++)
            begin
                prog.push_back(enc_load(3'd1, 16'(base) + 16'(4 * i)));
                prog.push_back(enc_min(3'd2, 3'd2, 3'd1));
                prog.push_back(enc_max(3'd3, 3'd3, 3'd1));
            end
            prog.push_back(enc_store(3'd2, 16'(res)));
            prog.push_back(enc_store(3'd3, 16'(res) + 16'd4));
            prog.push_back(enc_halt());
            execute_program(prog, 1'b0, 14'h0);
            read_words(res, 2);
        end

        current_test = "busy_handshake";
        host_drive(1'b1, 14'h0C00, $urandom);
        host_release();
        prog = {};
        prog.push_back(enc_li(3'd1, 16'($urandom)));
        prog.push_back(enc_store(3'd1, 16'h0C04));
        prog.push_back(enc_li(3'd2, 16'($urandom)));
        prog.push_back(enc_li(3'd3, 16'($urandom)));
        prog.push_back(enc_li(3'd4, 16'($urandom)));
        prog.push_back(enc_li(3'd5, 16'($urandom)));
        prog.push_back(enc_store(3'd2, 16'h0C08));
        prog.push_back(enc_halt());
        execute_program(prog, 1'b1, 14'h0C00);
        read_words(14'h0C00, 3);

        current_test = "unnamed_opcode";
        host_drive(1'b1, 14'h0D00, $urandom);
        host_release();
        prog = {};
        prog.push_back(enc_li(3'd1, 16'($urandom)));
        prog.push_back(enc_unnamed(4'd12));
        prog.push_back(enc_store(3'd1, 16'h0D00));
        prog.push_back(enc_halt());
        execute_program(prog, 1'b0, 14'h0);
        read_words(14'h0D00, 1);

        current_test = "reset_retention";
        host_drive(1'b1, 14'h0E00, $urandom);
        host_release();
        apply_reset();
        host_drive(1'b0, 14'h0E00, 32'h0);
        host_drive(1'b0, 14'h0100, 32'h0);
        host_release();
        drain_responses();

        $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0)
        begin
            $display(">>> PASS");
        end
        else
        begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== hw/minmax_system.sv ====
module minmax_system
    import cpu_pkg::*;
#(
    parameter int unsigned mem_size  = 32'h4000,
    parameter int unsigned code_base = 32'h3000,
    localparam int addr_w = $clog2(mem_size)
)
(
    input  logic              mem_write,
    input  logic              rst_n,
    input  logic              start_valid,
    output logic              start_ready,
    output logic              busy,
    input  logic              host_valid,
    output logic              host_ready,
    input  logic              host_we,
    input  logic [addr_w-1:0] host_addr,
    input  logic [word_w-1:0] host_wdata,
    output logic              host_rvalid,
    output logic [word_w-1:0] host_rdata
);

    logic [addr_w-1:0]     inst_addr;
    logic [word_w-1:0]     instr;
    logic [addr_w-1:0]     data_addr;
    logic [word_w-1:0]     data_wdata;
    logic                  data_re;
    logic                  data_we;
    logic [word_w-1:0]     data_rdata;
    logic [reg_addr_w-1:0] rf_raddr_a;
    logic [reg_addr_w-1:0] rf_raddr_b;
    logic [reg_addr_w-1:0] rf_waddr;
    logic                  rf_we;
    logic [word_w-1:0]     rf_wdata;
    logic [word_w-1:0]     rf_rdata_a;
    logic [word_w-1:0]     rf_rdata_b;
    alu_op_t               alu_op;
    logic [word_w-1:0]     imm_ext;
    logic [word_w-1:0]     alu_result;

    core_control #(
        .mem_size  (mem_size),
        .code_base (code_base)
    ) i_core_control (
        .mem_write   (mem_write),
        .rst_n       (rst_n),
        .start_valid (start_valid),
        .start_ready (start_ready),
        .busy        (busy),
        .host_valid  (host_valid),
        .host_ready  (host_ready),
        .host_we     (host_we),
        .host_addr   (host_addr),
        .host_wdata  (host_wdata),
        .host_rvalid (host_rvalid),
        .host_rdata  (host_rdata),
        .inst_addr   (inst_addr),
        .instr       (instr),
        .data_addr   (data_addr),
        .data_wdata  (data_wdata),
        .data_re     (data_re),
        .data_we     (data_we),
        .data_rdata  (data_rdata),
        .rf_raddr_a  (rf_raddr_a),
        .rf_raddr_b  (rf_raddr_b),
        .rf_waddr    (rf_waddr),
        .rf_we       (rf_we),
        .rf_wdata    (rf_wdata),
        .rf_rdata_b  (rf_rdata_b),
        .alu_op      (alu_op),
        .imm_ext     (imm_ext),
        .alu_result  (alu_result)
    );

    byte_memory #(
        .mem_size (mem_size)
    ) i_byte_memory (
        .mem_write  (mem_write),
        .inst_addr  (inst_addr),
        .instr      (instr),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_re    (data_re),
        .data_we    (data_we),
        .data_rdata (data_rdata)
    );

    register_file i_register_file (
        .mem_write (mem_write),
        .raddr_a   (rf_raddr_a),
        .raddr_b   (rf_raddr_b),
        .waddr     (rf_waddr),
        .we        (rf_we),
        .wdata     (rf_wdata),
        .rdata_a   (rf_rdata_a),
        .rdata_b   (rf_rdata_b)
    );

    alu i_alu (
        .op      (alu_op),
        .a       (rf_rdata_a),
        .b       (rf_rdata_b),
        .imm_ext (imm_ext),
        .result  (alu_result)
    );

endmodule

// ==== hw/core_control.sv ====
module core_control
    import cpu_pkg::*;
#(
    parameter int unsigned mem_size  = 32'h4000,
    parameter int unsigned code_base = 32'h3000,
    localparam int addr_w = $clog2(mem_size)
)
(
    input  logic                  mem_write,
    input  logic                  rst_n,
    input  logic                  start_valid,
    output logic                  start_ready,
    output logic                  busy,
    input  logic                  host_valid,
    output logic                  host_ready,
    input  logic                  host_we,
    input  logic [addr_w-1:0]     host_addr,
    input  logic [word_w-1:0]     host_wdata,
    output logic                  host_rvalid,
    output logic [word_w-1:0]     host_rdata,
    output logic [addr_w-1:0]     inst_addr,
    input  logic [word_w-1:0]     instr,
    output logic [addr_w-1:0]     data_addr,
    output logic [word_w-1:0]     data_wdata,
    output logic                  data_re,
    output logic                  data_we,
    input  logic [word_w-1:0]     data_rdata,
    output logic [reg_addr_w-1:0] rf_raddr_a,
    output logic [reg_addr_w-1:0] rf_raddr_b,
    output logic [reg_addr_w-1:0] rf_waddr,
    output logic                  rf_we,
    output logic [word_w-1:0]     rf_wdata,
    input  logic [word_w-1:0]     rf_rdata_b,
    output alu_op_t               alu_op,
    output logic [word_w-1:0]     imm_ext,
    input  logic [word_w-1:0]     alu_result
);

    ctrl_state_t       state;
    logic [addr_w-1:0] pc;
    logic [word_w-1:0] ir;
    opcode_t           fetched_op;
    opcode_t           ir_op;
    logic              fetched_halt;
    logic [word_w-1:0] imm_zext;
    logic              start_fire;
    logic              host_read;

    assign fetched_op = opcode_t'(instr[op_msb:op_lsb]);
    assign ir_op      = opcode_t'(ir[op_msb:op_lsb]);

    // anything outside the named set stops the core
    assign fetched_halt = !(fetched_op inside {op_li, op_load, op_store,
                                               op_add, op_sub, op_min, op_max});

    assign imm_ext  = {{(word_w - imm_w){ir[imm_msb]}}, ir[imm_msb:imm_lsb]};
    assign imm_zext = {{(word_w - imm_w){1'b0}}, ir[imm_msb:imm_lsb]};

    assign start_ready = (state == st_idle);
    assign host_ready  = (state == st_idle);
    assign start_fire  = start_valid & start_ready;
    assign host_read   = host_valid & host_ready & ~host_we;

    assign inst_addr  = pc;
    assign host_rdata = data_rdata;
    assign rf_raddr_a = ir[rs1_msb:rs1_lsb];
    assign rf_raddr_b = ir[rs2_msb:rs2_lsb];
    assign rf_waddr   = ir[rd_msb:rd_lsb];

    always_ff @(posedge mem_write)
    begin
        if (!rst_n)
        begin
            state       <= st_idle;
            busy        <= 1'b0;
            host_rvalid <= 1'b0;
            pc          <= addr_w'(code_base);
        end
        else
        begin
            // one response per accepted read, no stall
            host_rvalid <= host_read;
            case (state)
                st_idle:
                begin
                    if (start_fire)
                    begin
                        pc    <= addr_w'(code_base);
                        busy  <= 1'b1;
                        state <= st_fetch;
                    end
                end
                st_fetch:
                begin
                    state <= st_decode;
                end
                st_decode:
                begin
                    pc <= pc + addr_w'(word_bytes);
                    if (fetched_halt)
                    begin
                        busy  <= 1'b0;
                        state <= st_idle;
                    end
                    else
                    begin
                        state <= st_execute;
                    end
                end
                st_execute:
                begin
                    state <= (ir_op == op_load) ? st_load_wb : st_fetch;
                end
                default:
                begin
                    state <= st_fetch;
                end
            endcase
        end
    end

    always_ff @(posedge mem_write)
    begin
        if (state == st_decode)
        begin
            ir <= instr;
        end
    end

    always_comb
    begin
        case (ir_op)
            op_add:  alu_op = alu_add;
            op_sub:  alu_op = alu_sub;
            op_min:  alu_op = alu_min;
            op_max:  alu_op = alu_max;
            default: alu_op = alu_pass;
        endcase
    end

    // data port is shared, host owns it only in idle
    always_comb
    begin
        data_addr  = imm_zext[addr_w-1:0];
        data_wdata = rf_rdata_b;
        data_re    = 1'b0;
        data_we    = 1'b0;
        rf_we      = 1'b0;
        rf_wdata   = alu_result;
        case (state)
            st_idle:
            begin
                data_addr  = host_addr;
                data_wdata = host_wdata;
                data_re    = host_read;
                data_we    = host_valid & host_we;
            end
            st_execute:
            begin
                case (ir_op)
                    op_li, op_add, op_sub, op_min, op_max: rf_we = 1'b1;
                    op_store: data_we = 1'b1;
                    op_load:  data_re = 1'b1;
                    default:  rf_we = 1'b0;
                endcase
            end
            st_load_wb:
            begin
                rf_we    = 1'b1;
                rf_wdata = data_rdata;
            end
            default:
            begin
                rf_we = 1'b0;
            end
        endcase
    end

endmodule

// ==== hw/alu.sv ====
module alu
    import cpu_pkg::*;
(
    input  alu_op_t           op,
    input  logic [word_w-1:0] a,
    input  logic [word_w-1:0] b,
    input  logic [word_w-1:0] imm_ext,
    output logic [word_w-1:0] result
);

    logic a_less;

    // two's complement compare for min and max
    assign a_less = $signed(a) < $signed(b);

    always_comb
    begin
        case (op)
            alu_add:
            begin
                result = a + b;
            end
            alu_sub:
            begin
                result = a - b;
            end
            alu_min:
            begin
                result = a_less ? a : b;
            end
            alu_max:
            begin
                result = a_less ? b : a;
            end
            // li just forwards the sign-extended immediate
            default:
            begin
                result = imm_ext;
            end
        endcase
    end

endmodule

// ==== hw/register_file.sv ====
module register_file
    import cpu_pkg::*;
(
    input  logic                  mem_write,
    input  logic [reg_addr_w-1:0] raddr_a,
    input  logic [reg_addr_w-1:0] raddr_b,
    input  logic [reg_addr_w-1:0] waddr,
    input  logic                  we,
    input  logic [word_w-1:0]     wdata,
    output logic [word_w-1:0]     rdata_a,
    output logic [word_w-1:0]     rdata_b
);

    // r0 is a normal register, not hardwired
    logic [word_w-1:0] regs [reg_count];

    // asynchronous reads
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

    always_ff @(posedge mem_write)
    begin
        if (we)
        begin
            regs[waddr] <= wdata;
        end
    end

endmodule

// ==== hw/byte_memory.sv ====
module byte_memory
    import cpu_pkg::*;
#(
    parameter int unsigned mem_size = 32'h4000,
    localparam int addr_w = $clog2(mem_size)
)
(
    input  logic              mem_write,
    input  logic [addr_w-1:0] inst_addr,
    output logic [word_w-1:0] instr,
    input  logic [addr_w-1:0] data_addr,
    input  logic [word_w-1:0] data_wdata,
    input  logic              data_re,
    input  logic              data_we,
    output logic [word_w-1:0] data_rdata
);

    // data 0x0000..0x2ffc, code 0x3000..0x3ffc
    logic [7:0] mem [mem_size];

    logic [addr_w-1:0] inst_base;
    logic [addr_w-1:0] data_base;

    // low two address bits ignored
    assign inst_base = {inst_addr[addr_w-1:2], 2'b00};
    assign data_base = {data_addr[addr_w-1:2], 2'b00};

    // instruction port, read every cycle
    always_ff @(posedge mem_write)
    begin
        for (int b = 0; b < word_bytes; b++)
        begin
            instr[8*b +: 8] <= mem[inst_base + addr_w'(b)];
        end
    end

    // data port, little endian byte order
    always_ff @(posedge mem_write)
    begin
        if (data_we)
        begin
            for (int b = 0; b < word_bytes; b++)
            begin
                mem[data_base + addr_w'(b)] <= data_wdata[8*b +: 8];
            end
        end
        // read sees the word as it was before a same-edge write
        if (data_re)
        begin
            for (int b = 0; b < word_bytes; b++)
            begin
                data_rdata[8*b +: 8] <= mem[data_base + addr_w'(b)];
            end
        end
    end

endmodule

// ==== hw/cpu_pkg.sv ====
package cpu_pkg;

    // data path widths
    localparam int word_w     = 32;
    localparam int word_bytes = word_w / 8;
    localparam int reg_addr_w = 3;
    localparam int reg_count  = 8;

    // instruction fields
    localparam int op_msb  = 31;
    localparam int op_lsb  = 28;
    localparam int rd_msb  = 27;
    localparam int rd_lsb  = 25;
    localparam int rs1_msb = 24;
    localparam int rs1_lsb = 22;
    localparam int rs2_msb = 21;
    localparam int rs2_lsb = 19;
    localparam int imm_msb = 15;
    localparam int imm_lsb = 0;
    localparam int imm_w   = imm_msb - imm_lsb + 1;

    // codes 8 to 15 are unnamed and behave as halt
    typedef enum logic [3:0] {
        op_halt  = 4'd0,
        op_li    = 4'd1,
        op_load  = 4'd2,
        op_store = 4'd3,
        op_add   = 4'd4,
        op_sub   = 4'd5,
        op_min   = 4'd6,
        op_max   = 4'd7
    } opcode_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_min,
        alu_max,
        alu_pass
    } alu_op_t;

    typedef enum logic [2:0] {
        st_idle,
        st_fetch,
        st_decode,
        st_execute,
        st_load_wb
    } ctrl_state_t;

endpackage
